/* project.f */
design/alpu_op_pkg.sv
design/alpu_result_pkg.sv
design/alpu_inverter.sv
design/alpu_add_cla_lh.sv
design/alpu_add_cla_uh.sv
design/alpu_comb_piped.sv
design/alpu_shift_piped.sv
design/alpu_decode.sv
design/alpu_result_merge.sv
design/alpu_top.sv
dv/alpu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module alpu_tb -Mdir obj_dir -f project.f
	out="$$(./obj_dir/Valpu_tb)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* dv/alpu_tb.sv */
// checks REG_WIDTH 16 only, needs delay support and stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

module alpu_tb
  import alpu_op_pkg::*;
  import alpu_result_pkg::*;
;

  localparam int          REG_WIDTH    = 16;
  localparam int          AMT_W        = $clog2(REG_WIDTH);
  localparam int unsigned RESET_CYCLES = 16;
  localparam logic [31:0] LFSR_SEED    = 32'hfc5b1eac;
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;
  localparam int          NUM_ENTRIES  = 30;

  // operand source of a table entry
  localparam logic [1:0] SRC_FIXED   = 2'd0;
  localparam logic [1:0] SRC_RAND    = 2'd1;
  localparam logic [1:0] SRC_RAND_OP = 2'd2;

  typedef struct packed {
    alpu_opcode_e         op;
    logic [1:0]           src;
    logic [REG_WIDTH-1:0] a;
    logic [REG_WIDTH-1:0] b;
    logic                 cin;
    logic                 stall;
    logic [15:0]          count;
    logic [REG_WIDTH-1:0] exp_res;
    alpu_flags_t          exp_flags;
  } entry_t;

  typedef struct packed {
    logic [REG_WIDTH-1:0] res;
    alpu_flags_t          flags;
    logic [31:0]          due;
  } expect_t;

  // op, src, a, b, cin, stall, count, expected result, flags {zero, negative, carry}
  localparam entry_t TABLE [0:NUM_ENTRIES-1] = '{
    '{ADD,  SRC_FIXED,   16'hffff, 16'h0001, 1'b0, 1'b1, 16'd1,   16'h0000, 3'b101},
    '{ADD,  SRC_FIXED,   16'h1234, 16'h4321, 1'b0, 1'b0, 16'd1,   16'h5555, 3'b000},
    '{ADD,  SRC_FIXED,   16'h0001, 16'h0002, 1'b1, 1'b0, 16'd1,   16'h0003, 3'b000},
    '{ADC,  SRC_FIXED,   16'hffff, 16'h0000, 1'b1, 1'b0, 16'd1,   16'h0000, 3'b101},
    '{ADC,  SRC_FIXED,   16'h7fff, 16'h0000, 1'b1, 1'b0, 16'd1,   16'h8000, 3'b010},
    '{SUB,  SRC_FIXED,   16'h0000, 16'h0000, 1'b0, 1'b0, 16'd1,   16'h0000, 3'b100},
    '{SUB,  SRC_FIXED,   16'h0005, 16'h0003, 1'b0, 1'b0, 16'd1,   16'hfffe, 3'b010},
    '{SUB,  SRC_FIXED,   16'h0003, 16'h0005, 1'b0, 1'b0, 16'd1,   16'h0002, 3'b001},
    '{SUB,  SRC_FIXED,   16'h0001, 16'h0001, 1'b1, 1'b0, 16'd1,   16'h0000, 3'b101},
    '{AND,  SRC_FIXED,   16'hf0f0, 16'hff00, 1'b0, 1'b0, 16'd1,   16'hf000, 3'b010},
    '{AND,  SRC_FIXED,   16'h0000, 16'hffff, 1'b1, 1'b0, 16'd1,   16'h0000, 3'b100},
    '{OR,   SRC_FIXED,   16'h0f00, 16'h00f0, 1'b0, 1'b0, 16'd1,   16'h0ff0, 3'b000},
    '{XOR,  SRC_FIXED,   16'haaaa, 16'haaaa, 1'b0, 1'b0, 16'd1,   16'h0000, 3'b100},
    '{NOT,  SRC_FIXED,   16'hffff, 16'h1234, 1'b0, 1'b1, 16'd1,   16'h0000, 3'b100},
    '{NOT,  SRC_FIXED,   16'h00ff, 16'h0000, 1'b0, 1'b0, 16'd1,   16'hff00, 3'b010},
    '{NAND, SRC_FIXED,   16'hffff, 16'hffff, 1'b0, 1'b0, 16'd1,   16'h0000, 3'b100},
    '{NOR,  SRC_FIXED,   16'h0000, 16'h0000, 1'b0, 1'b0, 16'd1,   16'hffff, 3'b010},
    '{SHL,  SRC_FIXED,   16'h8001, 16'h0000, 1'b0, 1'b0, 16'd1,   16'h8001, 3'b010},
    '{SHL,  SRC_FIXED,   16'h8001, 16'h0001, 1'b0, 1'b0, 16'd1,   16'h0002, 3'b001},
    '{SHL,  SRC_FIXED,   16'h0003, 16'h000f, 1'b0, 1'b1, 16'd1,   16'h8000, 3'b011},
    '{SHR,  SRC_FIXED,   16'h0001, 16'h0000, 1'b0, 1'b0, 16'd1,   16'h0001, 3'b000},
    '{SHR,  SRC_FIXED,   16'h8001, 16'h0001, 1'b0, 1'b0, 16'd1,   16'h4000, 3'b001},
    '{SHR,  SRC_FIXED,   16'h8000, 16'h000f, 1'b0, 1'b0, 16'd1,   16'h0001, 3'b000},
    '{SRA,  SRC_FIXED,   16'h4000, 16'h0010, 1'b0, 1'b0, 16'd1,   16'h4000, 3'b000},
    '{SRA,  SRC_FIXED,   16'h8003, 16'h0001, 1'b0, 1'b0, 16'd1,   16'hc001, 3'b011},
    '{SRA,  SRC_FIXED,   16'h0001, 16'h0001, 1'b0, 1'b0, 16'd1,   16'h0000, 3'b101},
    '{SRA,  SRC_FIXED,   16'h8000, 16'h000f, 1'b0, 1'b0, 16'd1,   16'hffff, 3'b010},
    '{ADD,  SRC_RAND_OP, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'd240, 16'h0000, 3'b000},
    '{ADD,  SRC_RAND_OP, 16'h0000, 16'h0000, 1'b0, 1'b1, 16'd240, 16'h0000, 3'b000},
    '{SRA,  SRC_RAND,    16'h0000, 16'h0000, 1'b0, 1'b1, 16'd40,  16'h0000, 3'b000}
  };

  logic                 clk = 1'b0;
  logic                 reset_n;
  logic                 in_valid;
  alpu_opcode_e         opcode;
  logic [REG_WIDTH-1:0] a;
  logic [REG_WIDTH-1:0] b;
  logic                 cin;
  logic                 pipe_active;
  logic [REG_WIDTH-1:0] result;
  alpu_flags_t          flags;
  logic                 out_valid;

  logic [31:0]          lfsr_state;
  expect_t              exp_q[$];
  logic [31:0]          edge_count = '0;
  logic                 last_load = 1'b0;
  int unsigned          cycle_count = 0;
  int unsigned          cycle_limit;

  alpu_top #(
    .REG_WIDTH(REG_WIDTH)
  ) alpu_top_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .in_valid    (in_valid),
    .opcode      (opcode),
    .a           (a),
    .b           (b),
    .cin         (cin),
    .pipe_active (pipe_active),
    .result      (result),
    .flags       (flags),
    .out_valid   (out_valid)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // galois lfsr, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // expected result and flags straight from the opcode rules
  function automatic expect_t model_op(input alpu_opcode_e op, input logic [REG_WIDTH-1:0] op_a,
                                       input logic [REG_WIDTH-1:0] op_b, input logic op_cin);
    logic [REG_WIDTH:0]   wide;
    logic [REG_WIDTH-1:0] neg_a;
    logic [REG_WIDTH-1:0] r;
    logic                 c;
    int                   amt;
    expect_t              e;
    wide  = '0;
    r     = '0;
    c     = 1'b0;
    amt   = int'(op_b[AMT_W-1:0]);
    neg_a = ~op_a + REG_WIDTH'(1);
    case (op)
      ADD:  wide = {1'b0, op_a} + {1'b0, op_b};
      ADC:  wide = {1'b0, op_a} + {1'b0, op_b} + {{REG_WIDTH{1'b0}}, op_cin};
      SUB:  wide = {1'b0, op_b} + {1'b0, neg_a};
      AND:  r = op_a & op_b;
      OR:   r = op_a | op_b;
      XOR:  r = op_a ^ op_b;
      NOT:  r = ~op_a;
      NAND: r = ~(op_a & op_b);
      NOR:  r = ~(op_a | op_b);
      SHL: begin
        r = op_a << amt;
        c = (amt != 0) ? op_a[REG_WIDTH-amt] : 1'b0;
      end
      SHR: begin
        r = op_a >> amt;
        c = (amt != 0) ? op_a[amt-1] : 1'b0;
      end
      SRA: begin
        r = $signed(op_a) >>> amt;
        c = (amt != 0) ? op_a[amt-1] : 1'b0;
      end
      default: r = '0;
    endcase
    if (op inside {ADD, ADC, SUB}) begin
      r = wide[REG_WIDTH-1:0];
      c = wide[REG_WIDTH];
    end
    e.res            = r;
    e.flags.zero     = (r == '0);
    e.flags.negative = r[REG_WIDTH-1];
    e.flags.carry    = c;
    e.due            = '0;
    return e;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // retries each cycle until the op is sampled with pipe_active high
  task automatic issue_op(input alpu_opcode_e op, input logic [REG_WIDTH-1:0] op_a,
                          input logic [REG_WIDTH-1:0] op_b, input logic op_cin,
                          input logic stall, input expect_t exp);
    logic    go;
    logic    bubble;
    logic    accepted;
    expect_t e;
    accepted = 1'b0;
    e        = exp;
    while (!accepted) begin
      @(posedge clk);
      #1;
      go          = stall ? (take_bits(2) != 32'd0) : 1'b1;
      bubble      = stall ? (take_bits(2) == 32'd0) : 1'b0;
      pipe_active = go;
      in_valid    = !bubble;
      opcode      = op;
      a           = op_a;
      b           = op_b;
      cin         = op_cin;
      if (go && !bubble) begin
        e.due = edge_count + 32'd4;
        exp_q.push_back(e);
        accepted = 1'b1;
      end
    end
  endtask

  // --------------------------------------------------
  // monitor
  // --------------------------------------------------
  always @(posedge clk) begin
    last_load   <= reset_n && pipe_active;
    cycle_count <= cycle_count + 1;
    if (reset_n && pipe_active) begin
      edge_count <= edge_count + 32'd1;
    end
  end

  // a held output counts once, on the edge that loaded it
  always @(negedge clk) begin
    expect_t exp;
    if (cycle_count > cycle_limit) begin
      $display("timeout: no end of run after %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end else if (!reset_n) begin
      check_value("out_valid", 32'd0, 32'(out_valid));
    end else if (last_load && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid high at %0t with no operation outstanding", $time);
        $display("TESTS FAILED");
        $fatal(1, "unexpected output");
      end else begin
        exp = exp_q.pop_front();
        check_value("result", 32'(exp.res), 32'(result));
        check_value("flags", 32'(exp.flags), 32'(flags));
        check_value("out_edge", exp.due, edge_count);
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    int unsigned          total_ops;
    entry_t               ent;
    alpu_opcode_e         op;
    logic [REG_WIDTH-1:0] op_a;
    logic [REG_WIDTH-1:0] op_b;
    logic                 op_cin;
    expect_t              exp;
    reset_n     = 1'b0;
    in_valid    = 1'b0;
    opcode      = ADD;
    a           = '0;
    b           = '0;
    cin         = 1'b0;
    pipe_active = 1'b1;
    lfsr_state  = LFSR_SEED;
    total_ops   = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      total_ops = total_ops + 32'(TABLE[i].count);
    end
    cycle_limit = 2 * total_ops * 6 + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;
    // idle enabled cycles, nothing may come out yet
    repeat (6) @(posedge clk);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      ent = TABLE[i];
      for (int k = 0; k < int'(ent.count); k++) begin
        op     = ent.op;
        op_a   = ent.a;
        op_b   = ent.b;
        op_cin = ent.cin;
        if (ent.src == SRC_RAND_OP) begin
          op = alpu_opcode_e'(4'(take_bits(4) % 32'd12));
        end
        if (ent.src != SRC_FIXED) begin
          op_a   = REG_WIDTH'(take_bits(REG_WIDTH));
          op_b   = REG_WIDTH'(take_bits(REG_WIDTH));
          op_cin = 1'(take_bits(1));
          exp    = model_op(op, op_a, op_b, op_cin);
        end else begin
          exp.res   = ent.exp_res;
          exp.flags = ent.exp_flags;
          exp.due   = '0;
        end
        issue_op(op, op_a, op_b, op_cin, ent.stall, exp);
      end
    end

    @(posedge clk);
    #1;
    in_valid    = 1'b0;
    pipe_active = 1'b1;
    // last result needs four enabled edges, the rest catch stray outputs
    repeat (12) @(posedge clk);

    if (exp_q.size() != 0) begin
      $display("run ended with %0d results missing", exp_q.size());
      $display("TESTS FAILED");
      $fatal(1, "missing results");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* design/alpu_top.sv */
// four-stage latency counted in pipe_active-high edges, one operation per cycle
`timescale 1ns/1ns
`default_nettype none

module alpu_top
  import alpu_op_pkg::*;
  import alpu_result_pkg::*;
#(
  parameter int REG_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 in_valid,
  input  alpu_opcode_e         opcode,
  input  logic [REG_WIDTH-1:0] a,
  input  logic [REG_WIDTH-1:0] b,
  input  logic                 cin,
  input  logic                 pipe_active,
  output logic [REG_WIDTH-1:0] result,
  output alpu_flags_t          flags,
  output logic                 out_valid
);

  alpu_ctrl_t           ctrl;
  logic                 shift_left;
  logic                 shift_arith;
  alpu_issue_t          issue;
  logic [REG_WIDTH-1:0] alu_out;
  logic                 alu_cout;
  logic [REG_WIDTH-1:0] shift_res;
  logic                 shift_cout;
  logic                 valid_s2;
  alpu_opcode_e         opcode_s2;

  // carry-in only counts for ADC
  assign issue = '{
    valid:  in_valid,
    opcode: opcode,
    a:      DEFAULT_REG_WIDTH'(a),
    b:      DEFAULT_REG_WIDTH'(b),
    cin:    cin & (opcode == ADC)
  };

  alpu_decode decode_inst (
    .opcode      (opcode),
    .ctrl        (ctrl),
    .shift_left  (shift_left),
    .shift_arith (shift_arith)
  );

  alpu_comb_piped #(
    .REG_WIDTH(REG_WIDTH)
  ) comb_piped_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .a           (a),
    .b           (b),
    .ctrl        (ctrl),
    .cin         (issue.cin),
    .pipe_active (pipe_active),
    .out         (alu_out),
    .cout        (alu_cout)
  );

  alpu_shift_piped #(
    .REG_WIDTH(REG_WIDTH)
  ) shift_piped_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .pipe_active (pipe_active),
    .issue       (issue),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .shift_res   (shift_res),
    .shift_cout  (shift_cout),
    .valid_s2    (valid_s2),
    .opcode_s2   (opcode_s2)
  );

  alpu_result_merge #(
    .REG_WIDTH(REG_WIDTH)
  ) result_merge_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .pipe_active (pipe_active),
    .alu_out     (alu_out),
    .alu_cout    (alu_cout),
    .shift_res   (shift_res),
    .shift_cout  (shift_cout),
    .valid_s2    (valid_s2),
    .opcode_s2   (opcode_s2),
    .result      (result),
    .flags       (flags),
    .out_valid   (out_valid)
  );

endmodule

`default_nettype wire

/* design/alpu_result_merge.sv */
// one output register stage that holds while pipe_active is low
`timescale 1ns/1ns
`default_nettype none

module alpu_result_merge
  import alpu_op_pkg::*;
  import alpu_result_pkg::*;
#(
  parameter int REG_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 pipe_active,
  input  logic [REG_WIDTH-1:0] alu_out,
  input  logic                 alu_cout,
  input  logic [REG_WIDTH-1:0] shift_res,
  input  logic                 shift_cout,
  input  logic                 valid_s2,
  input  alpu_opcode_e         opcode_s2,
  output logic [REG_WIDTH-1:0] result,
  output alpu_flags_t          flags,
  output logic                 out_valid
);

  logic                 is_shift;
  logic                 is_arith;
  logic [REG_WIDTH-1:0] sel_res;
  alpu_flags_t          sel_flags;

  // pick by opcode class, logic ops never carry
  always_comb begin
    is_shift = opcode_s2 inside {SHL, SHR, SRA};
    is_arith = opcode_s2 inside {ADD, ADC, SUB};
    sel_res  = is_shift ? shift_res : alu_out;
    sel_flags.zero     = (sel_res == '0);
    sel_flags.negative = sel_res[REG_WIDTH-1];
    sel_flags.carry    = is_shift ? shift_cout : (is_arith & alu_cout);
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      result    <= '0;
      flags     <= '0;
      out_valid <= 1'b0;
    end else if (pipe_active) begin
      result    <= sel_res;
      flags     <= sel_flags;
      out_valid <= valid_s2;
    end
  end

  // upstream stages must leave reset empty
  assert property (@(posedge clk) $rose(reset_n) |=> !out_valid)
    else $error("alpu_result_merge: out_valid high right after reset");

endmodule

`default_nettype wire

/* design/alpu_decode.sv */
// combinational, undefined opcode encodings decode to an all-zero control word
`timescale 1ns/1ns
`default_nettype none

module alpu_decode
  import alpu_op_pkg::*;
(
  input  alpu_opcode_e opcode,
  output alpu_ctrl_t   ctrl,
  output logic         shift_left,
  output logic         shift_arith
);

  always_comb begin
    ctrl = '0;
    case (opcode)
      ADD, ADC: begin
        ctrl.cgen_en  = 1'b1;
        ctrl.carry_en = 1'b1;
        ctrl.sel_sum  = 1'b1;
      end
      // b + (-a)
      SUB: begin
        ctrl.twos_en  = 1'b1;
        ctrl.cgen_en  = 1'b1;
        ctrl.carry_en = 1'b1;
        ctrl.sel_sum  = 1'b1;
      end
      AND, NAND: begin
        ctrl.cgen_en = 1'b1;
        ctrl.sel_gen = 1'b1;
        ctrl.out_inv = (opcode == NAND);
      end
      OR, NOR: begin
        ctrl.cgen_en = 1'b1;
        ctrl.prop_or = 1'b1;
        ctrl.sel_gen = 1'b1;
        ctrl.out_inv = (opcode == NOR);
      end
      // sum with no carries is the plain propagate
      XOR: begin
        ctrl.sel_sum = 1'b1;
      end
      // ~a xor masked b
      NOT: begin
        ctrl.all_en  = 1'b1;
        ctrl.sel_sum = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  assign shift_left  = (opcode == SHL);
  assign shift_arith = (opcode == SRA);

endmodule

`default_nettype wire

/* design/alpu_shift_piped.sv */
// three stages, REG_WIDTH a power of two no wider than DEFAULT_REG_WIDTH
`timescale 1ns/1ns
`default_nettype none

module alpu_shift_piped
  import alpu_op_pkg::*;
#(
  parameter int REG_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 pipe_active,
  input  alpu_issue_t          issue,
  input  logic                 shift_left,
  input  logic                 shift_arith,
  output logic [REG_WIDTH-1:0] shift_res,
  output logic                 shift_cout,
  output logic                 valid_s2,
  output alpu_opcode_e         opcode_s2
);

  localparam int SH_W   = $clog2(REG_WIDTH);
  localparam int FINE_W = SH_W / 2;

  if (REG_WIDTH > DEFAULT_REG_WIDTH) begin : g_width_check
    $error("alpu_shift_piped: REG_WIDTH exceeds issue operand width");
  end

  // work vector is data plus one guard bit that catches the last bit out
  // left keeps the guard on top, right keeps it at bit 0
  function automatic logic [REG_WIDTH:0] shift_step(
    input logic [REG_WIDTH:0] x,
    input logic               left,
    input logic               fill,
    input logic [SH_W-1:0]    k
  );
    logic [2*REG_WIDTH+1:0] wide;
    begin
      wide = {{(REG_WIDTH+1){fill}}, x} >> k;
      if (left) begin
        shift_step = x << k;
      end else begin
        shift_step = wide[REG_WIDTH:0];
      end
    end
  endfunction

  // --------------------------------------------------
  // S0: operands and controls
  // --------------------------------------------------
  logic                 valid_s0;
  alpu_opcode_e         opcode_s0;
  logic [REG_WIDTH-1:0] a_s0;
  logic [SH_W-1:0]      amt_s0;
  logic                 left_s0;
  logic                 arith_s0;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_s0  <= 1'b0;
      opcode_s0 <= ADD;
      a_s0      <= '0;
      amt_s0    <= '0;
      left_s0   <= 1'b0;
      arith_s0  <= 1'b0;
    end else if (pipe_active) begin
      valid_s0  <= issue.valid;
      opcode_s0 <= issue.opcode;
      a_s0      <= issue.a[REG_WIDTH-1:0];
      amt_s0    <= issue.b[SH_W-1:0];
      left_s0   <= shift_left;
      arith_s0  <= shift_arith;
    end
  end

  // --------------------------------------------------
  // S1: coarse shift by the upper amount bits
  // --------------------------------------------------
  logic [REG_WIDTH:0]   work_s0;
  logic                 fill_s0;
  logic [SH_W-1:0]      coarse_amt;
  logic                 valid_s1;
  alpu_opcode_e         opcode_s1;
  logic [REG_WIDTH:0]   work_s1;
  logic [FINE_W-1:0]    fine_s1;
  logic                 left_s1;
  logic                 fill_s1;

  assign work_s0    = left_s0 ? {1'b0, a_s0} : {a_s0, 1'b0};
  assign fill_s0    = arith_s0 & a_s0[REG_WIDTH-1];
  assign coarse_amt = {amt_s0[SH_W-1:FINE_W], {FINE_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_s1  <= 1'b0;
      opcode_s1 <= ADD;
      work_s1   <= '0;
      fine_s1   <= '0;
      left_s1   <= 1'b0;
      fill_s1   <= 1'b0;
    end else if (pipe_active) begin
      valid_s1  <= valid_s0;
      opcode_s1 <= opcode_s0;
      work_s1   <= shift_step(work_s0, left_s0, fill_s0, coarse_amt);
      fine_s1   <= amt_s0[FINE_W-1:0];
      left_s1   <= left_s0;
      fill_s1   <= fill_s0;
    end
  end

  // --------------------------------------------------
  // S2: fine shift, split result and carry
  // --------------------------------------------------
  logic [REG_WIDTH:0]   work_fine;
  logic [REG_WIDTH-1:0] res_s2;
  logic                 cout_s2;

  assign work_fine = shift_step(work_s1, left_s1, fill_s1, SH_W'(fine_s1));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_s2  <= 1'b0;
      opcode_s2 <= ADD;
      res_s2    <= '0;
      cout_s2   <= 1'b0;
    end else if (pipe_active) begin
      valid_s2  <= valid_s1;
      opcode_s2 <= opcode_s1;
      res_s2    <= left_s1 ? work_fine[REG_WIDTH-1:0] : work_fine[REG_WIDTH:1];
      cout_s2   <= left_s1 ? work_fine[REG_WIDTH] : work_fine[0];
    end
  end

  assign shift_res  = res_s2;
  assign shift_cout = cout_s2;

  // opcode travels with valid from the top-level inputs
  assert property (@(posedge clk) disable iff (!reset_n)
    valid_s2 |-> !$isunknown(opcode_s2))
    else $error("alpu_shift_piped: unknown opcode with valid_s2");

endmodule

`default_nettype wire

/* design/alpu_comb_piped.sv */
// three stages, every stage holds while pipe_active is low, no handshake
`timescale 1ns/1ns
`default_nettype none

module alpu_comb_piped
  import alpu_op_pkg::*;
#(
  parameter int REG_WIDTH = 16
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic [REG_WIDTH-1:0] a,
  input  logic [REG_WIDTH-1:0] b,
  input  alpu_ctrl_t           ctrl,
  input  logic                 cin,
  input  logic                 pipe_active,
  output logic [REG_WIDTH-1:0] out,
  output logic                 cout
);

  // --------------------------------------------------
  // S0: invert/negate a, mask b
  // --------------------------------------------------
  logic [REG_WIDTH-1:0] inv_a;
  logic [REG_WIDTH-1:0] b_masked;
  logic [REG_WIDTH-1:0] inv_a_s0;
  logic [REG_WIDTH-1:0] b_s0;
  logic                 cin_s0;
  alpu_ctrl_t           ctrl_s0;

  alpu_inverter #(
    .REG_WIDTH(REG_WIDTH)
  ) inverter_inst (
    .a       (a),
    .twos_en (ctrl.twos_en),
    .all_en  (ctrl.all_en),
    .inv_a   (inv_a)
  );

  // b dropped for NOT
  assign b_masked = b & ~{REG_WIDTH{ctrl.all_en}};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      inv_a_s0 <= '0;
      b_s0     <= '0;
      cin_s0   <= 1'b0;
      ctrl_s0  <= '0;
    end else if (pipe_active) begin
      inv_a_s0 <= inv_a;
      b_s0     <= b_masked;
      cin_s0   <= cin;
      ctrl_s0  <= ctrl;
    end
  end

  // --------------------------------------------------
  // S1: propagate/generate plus OR path
  // --------------------------------------------------
  logic [REG_WIDTH-1:0] ox;
  logic [REG_WIDTH-1:0] cgen_raw;
  logic [REG_WIDTH-1:0] cgen;
  logic [REG_WIDTH-1:0] ox_s1;
  logic [REG_WIDTH-1:0] cgen_s1;
  logic                 cin_s1;
  alpu_ctrl_t           ctrl_s1;

  alpu_add_cla_lh #(
    .REG_WIDTH(REG_WIDTH)
  ) cla_lh_inst (
    .a       (inv_a_s0),
    .b       (b_s0),
    .cgen_en (ctrl_s0.cgen_en),
    .ox      (ox),
    .cgen    (cgen_raw)
  );

  // p | g gives a | b for OR/NOR
  assign cgen = cgen_raw | (ox & {REG_WIDTH{ctrl_s0.prop_or}});

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ox_s1   <= '0;
      cgen_s1 <= '0;
      cin_s1  <= 1'b0;
      ctrl_s1 <= '0;
    end else if (pipe_active) begin
      ox_s1   <= ox;
      cgen_s1 <= cgen;
      cin_s1  <= cin_s0;
      ctrl_s1 <= ctrl_s0;
    end
  end

  // --------------------------------------------------
  // S2: carries, select, output invert
  // --------------------------------------------------
  logic [REG_WIDTH-1:0] sum;
  logic                 cout_int;
  logic [REG_WIDTH-1:0] out_pre;
  logic [REG_WIDTH-1:0] out_s2;
  logic                 cout_s2;

  alpu_add_cla_uh #(
    .REG_WIDTH(REG_WIDTH)
  ) cla_uh_inst (
    .ox       (ox_s1),
    .cgen     (cgen_s1),
    .cin      (cin_s1),
    .carry_en (ctrl_s1.carry_en),
    .s        (sum),
    .cout     (cout_int)
  );

  assign out_pre = ((sum & {REG_WIDTH{ctrl_s1.sel_sum}}) |
                    (cgen_s1 & {REG_WIDTH{ctrl_s1.sel_gen}})) ^
                   {REG_WIDTH{ctrl_s1.out_inv}};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_s2  <= '0;
      cout_s2 <= 1'b0;
    end else if (pipe_active) begin
      out_s2  <= out_pre;
      cout_s2 <= cout_int;
    end
  end

  assign out  = out_s2;
  assign cout = cout_s2;

endmodule

`default_nettype wire

/* design/alpu_add_cla_uh.sv */
// combinational flat lookahead, depth grows with REG_WIDTH
`timescale 1ns/1ns
`default_nettype none

module alpu_add_cla_uh #(
  parameter int REG_WIDTH = 16
) (
  input  logic [REG_WIDTH-1:0] ox,
  input  logic [REG_WIDTH-1:0] cgen,
  input  logic                 cin,
  input  logic                 carry_en,
  output logic [REG_WIDTH-1:0] s,
  output logic                 cout
);

  logic [REG_WIDTH:0] carry;

  // c[i] = g[i-1] | p[i-1]g[i-2] | ... | p[i-1..0]c0
  always_comb begin
    logic c_acc;
    logic prop_run;
    carry = '0;
    for (int i = 1; i <= REG_WIDTH; i++) begin
      c_acc    = 1'b0;
      prop_run = 1'b1;
      for (int j = i - 1; j >= 0; j--) begin
        c_acc    = c_acc | (prop_run & cgen[j]);
        prop_run = prop_run & ox[j];
      end
      c_acc    = c_acc | (prop_run & cin);
      carry[i] = c_acc & carry_en;
    end
    // carry-in only enters when the chain is on
    carry[0] = cin & carry_en;
  end

  assign s    = ox ^ carry[REG_WIDTH-1:0];
  assign cout = carry[REG_WIDTH];

endmodule

`default_nettype wire

/* design/alpu_add_cla_lh.sv */
// combinational, generate terms are forced low when cgen_en is clear
`timescale 1ns/1ns
`default_nettype none

module alpu_add_cla_lh #(
  parameter int REG_WIDTH = 16
) (
  input  logic [REG_WIDTH-1:0] a,
  input  logic [REG_WIDTH-1:0] b,
  input  logic                 cgen_en,
  output logic [REG_WIDTH-1:0] ox,
  output logic [REG_WIDTH-1:0] cgen
);

  // per-bit propagate
  assign ox = a ^ b;

  // per-bit generate, also the AND result for logic ops
  assign cgen = (a & b) & {REG_WIDTH{cgen_en}};

endmodule

`default_nettype wire

/* design/alpu_inverter.sv */
// purely combinational, twos_en and all_en must never be set together
`timescale 1ns/1ns
`default_nettype none

module alpu_inverter #(
  parameter int REG_WIDTH = 16
) (
  input  logic [REG_WIDTH-1:0] a,
  input  logic                 twos_en,
  input  logic                 all_en,
  output logic [REG_WIDTH-1:0] inv_a
);

  // negate, invert or pass operand a
  always_comb begin
    if (twos_en) begin
      inv_a = ~a + REG_WIDTH'(1);
    end else if (all_en) begin
      inv_a = ~a;
    end else begin
      inv_a = a;
    end
  end

  // decoder must never ask for negate and invert at once
  always_comb begin
    if (!$isunknown({twos_en, all_en})) begin
      assert (!(twos_en && all_en))
        else $error("alpu_inverter: twos_en and all_en both set");
    end
  end

endmodule

`default_nettype wire

/* design/alpu_result_pkg.sv */
// flag encoding only, no overflow flag is produced
`default_nettype none

package alpu_result_pkg;

  // zero and negative follow the result, carry follows the opcode class
  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;
  } alpu_flags_t;

endpackage

`default_nettype wire

/* design/alpu_op_pkg.sv */
// issue operands are DEFAULT_REG_WIDTH wide and no module may run a wider REG_WIDTH
`default_nettype none

package alpu_op_pkg;

  // width of the operand fields carried in the issue bundle
  localparam int DEFAULT_REG_WIDTH = 16;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    ADC  = 4'd1,
    SUB  = 4'd2,
    AND  = 4'd3,
    OR   = 4'd4,
    XOR  = 4'd5,
    NOT  = 4'd6,
    NAND = 4'd7,
    NOR  = 4'd8,
    SHL  = 4'd9,
    SHR  = 4'd10,
    SRA  = 4'd11
  } alpu_opcode_e;

  // arithmetic/logic pipe control word, msb first
  typedef struct packed {
    logic twos_en;
    logic all_en;
    logic cgen_en;
    logic prop_or;
    logic carry_en;
    logic sel_sum;
    logic sel_gen;
    logic out_inv;
  } alpu_ctrl_t;

  typedef struct packed {
    logic                         valid;
    alpu_opcode_e                 opcode;
    logic [DEFAULT_REG_WIDTH-1:0] a;
    logic [DEFAULT_REG_WIDTH-1:0] b;
    logic                         cin;
  } alpu_issue_t;

endpackage

`default_nettype wire
